/* design/cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode (
  input  logic        clk,
  input  logic        rst,
  input  logic [7:0]  i_command,
  input  logic [31:0] i_rw_count,
  input  logic [31:0] i_address,
  input  logic        i_command_rdy_stb,
  input  logic [31:0] i_words_taken,
  input  logic        i_send_done,
  output logic        o_master_ready,
  output logic [2:0]  o_state,
  output logic        o_drain_en,
  output logic        o_send_go,
  output logic [7:0]  o_opcode,
  output logic [31:0] o_read_size,
  output logic [31:0] o_address
);

  logic [2:0]  state;
  logic [2:0]  next_state;
  logic [31:0] r_count;
  logic        r_take_data;
  logic        r_sent;
  logic        w_accept;
  logic        w_take_new;
  logic        w_data_done;

  // Strobe only counts in IDLE and with a known opcode
  assign w_accept = i_command_rdy_stb && (state == host_cmd_pkg::ST_IDLE) &&
                    (i_command inside {host_cmd_pkg::CMD_PING, host_cmd_pkg::CMD_WRITE,
                                       host_cmd_pkg::CMD_READ, host_cmd_pkg::CMD_CONFIG});

  // WRITE always takes data, CONFIG only with a non-zero count
  assign w_take_new = (i_command == host_cmd_pkg::CMD_WRITE) ||
                      ((i_command == host_cmd_pkg::CMD_CONFIG) && (i_rw_count != '0));

  assign w_data_done = !r_take_data || (i_words_taken >= r_count);

  assign o_state    = state;
  assign o_drain_en = (state != host_cmd_pkg::ST_IDLE) && r_take_data;

  always_comb begin
    next_state = state;
    if (state == host_cmd_pkg::ST_IDLE) begin
      if (w_accept) begin
        case (i_command)
          host_cmd_pkg::CMD_PING:   next_state = host_cmd_pkg::ST_PING;
          host_cmd_pkg::CMD_WRITE:  next_state = host_cmd_pkg::ST_WRITE;
          host_cmd_pkg::CMD_READ:   next_state = host_cmd_pkg::ST_READ;
          host_cmd_pkg::CMD_CONFIG: next_state = host_cmd_pkg::ST_CONFIG;
          default:                  next_state = host_cmd_pkg::ST_IDLE;
        endcase
      end
    end else if (i_send_done) begin
      next_state = host_cmd_pkg::ST_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= host_cmd_pkg::ST_IDLE;
      o_master_ready <= 1'b0;
      o_send_go      <= 1'b0;
      r_take_data    <= 1'b0;
      r_sent         <= 1'b0;
    end else begin
      state     <= next_state;
      o_send_go <= 1'b0;
      // Ready follows the state it is entering, so it lines up with o_state
      o_master_ready <= (next_state == host_cmd_pkg::ST_IDLE) ||
                        (w_accept ? w_take_new : r_take_data);
      if (w_accept) begin
        r_take_data <= w_take_new;
        r_sent      <= 1'b0;
      end else if ((state != host_cmd_pkg::ST_IDLE) && !r_sent && w_data_done) begin
        // One response per command
        o_send_go <= 1'b1;
        r_sent    <= 1'b1;
      end
    end
  end

  // Command fields captured at acceptance
  always_ff @(posedge clk) begin
    if (w_accept) begin
      o_opcode  <= i_command;
      o_address <= i_address;
      r_count   <= i_rw_count;
      case (i_command)
        host_cmd_pkg::CMD_READ:   o_read_size <= i_rw_count;
        host_cmd_pkg::CMD_CONFIG: o_read_size <= host_cmd_pkg::CONFIG_LENGTH;
        default:                  o_read_size <= '0;
      endcase
    end
  end

endmodule

/* design/host_cmd_pkg.sv */
package host_cmd_pkg;

  // Opcodes decoded from the host link
  localparam logic [7:0] CMD_PING   = 8'h00;
  localparam logic [7:0] CMD_WRITE  = 8'h01;
  localparam logic [7:0] CMD_READ   = 8'h02;
  localparam logic [7:0] CMD_CONFIG = 8'h03;

  // Command FSM state encoding
  localparam logic [2:0] ST_IDLE   = 3'd0;
  localparam logic [2:0] ST_PING   = 3'd1;
  localparam logic [2:0] ST_WRITE  = 3'd2;
  localparam logic [2:0] ST_READ   = 3'd3;
  localparam logic [2:0] ST_CONFIG = 3'd4;

  // Tag in the top half of a normal status header
  localparam logic [15:0] STATUS_ID_RESP = 16'hC0DE;

  // Data words carried by every CONFIG response
  localparam logic [31:0] CONFIG_LENGTH = 32'd4;

  // One outgoing FIFO word
  // The first word of a response is a status header, the rest are plain data
  typedef union packed {
    struct packed {
      logic [15:0] id;
      logic [7:0]  flags;
      // Bitwise inverse of the opcode being answered
      logic [7:0]  opcode_n;
    } hdr;
    logic [31:0] data;
  } resp_word_u;

endpackage

/* design/host_master.sv */
`timescale 1ns/1ps

module host_master (
  input  logic                     clk,
  input  logic                     rst,
  // Host command side
  input  logic [7:0]               i_command,
  input  logic [7:0]               i_flag,
  input  logic [31:0]              i_rw_count,
  input  logic [31:0]              i_address,
  input  logic                     i_command_rdy_stb,
  output logic                     o_master_ready,
  output host_cmd_pkg::resp_word_u o_status,
  output logic                     o_status_rdy_stb,
  // Incoming ping-pong FIFO
  input  logic                     i_wpath_ready,
  input  logic [23:0]              i_wpath_packet_size,
  output logic                     o_wpath_activate,
  output logic                     o_wpath_strobe,
  // Outgoing ping-pong FIFO
  input  logic [1:0]               i_rpath_ready,
  input  logic [23:0]              i_rpath_size,
  output logic [1:0]               o_rpath_activate,
  output host_cmd_pkg::resp_word_u o_rpath_data,
  output logic                     o_rpath_strobe
);

  logic [2:0]  cmd_state;
  logic        drain_en;
  logic        send_go;
  logic        send_done;
  logic [7:0]  opcode;
  logic [31:0] read_size;
  logic [31:0] address;
  logic [31:0] words_taken;

  cmd_decode u_decode (
    .clk               (clk),
    .rst               (rst),
    .i_command         (i_command),
    .i_rw_count        (i_rw_count),
    .i_address         (i_address),
    .i_command_rdy_stb (i_command_rdy_stb),
    .i_words_taken     (words_taken),
    .i_send_done       (send_done),
    .o_master_ready    (o_master_ready),
    .o_state           (cmd_state),
    .o_drain_en        (drain_en),
    .o_send_go         (send_go),
    .o_opcode          (opcode),
    .o_read_size       (read_size),
    .o_address         (address)
  );

  write_drain u_drain (
    .clk                 (clk),
    .rst                 (rst),
    .i_drain_en          (drain_en),
    .i_wpath_ready       (i_wpath_ready),
    .i_wpath_packet_size (i_wpath_packet_size),
    .o_wpath_activate    (o_wpath_activate),
    .o_wpath_strobe      (o_wpath_strobe),
    .o_words_taken       (words_taken)
  );

  response_sender u_sender (
    .clk              (clk),
    .rst              (rst),
    .i_send_go        (send_go),
    .i_opcode         (opcode),
    .i_read_size      (read_size),
    .i_address        (address),
    .i_flag           (i_flag),
    .i_rpath_ready    (i_rpath_ready),
    .i_rpath_size     (i_rpath_size),
    .o_rpath_activate (o_rpath_activate),
    .o_rpath_data     (o_rpath_data),
    .o_rpath_strobe   (o_rpath_strobe),
    .o_status         (o_status),
    .o_status_rdy_stb (o_status_rdy_stb),
    .o_send_done      (send_done)
  );

endmodule

/* design/response_sender.sv */
`timescale 1ns/1ps

module response_sender (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_send_go,
  input  logic [7:0]               i_opcode,
  input  logic [31:0]              i_read_size,
  input  logic [31:0]              i_address,
  input  logic [7:0]               i_flag,
  input  logic [1:0]               i_rpath_ready,
  input  logic [23:0]              i_rpath_size,
  output logic [1:0]               o_rpath_activate,
  output host_cmd_pkg::resp_word_u o_rpath_data,
  output logic                     o_rpath_strobe,
  output host_cmd_pkg::resp_word_u o_status,
  output logic                     o_status_rdy_stb,
  output logic                     o_send_done
);

  logic                     r_busy;
  logic                     r_finish;
  logic [31:0]              r_word_idx;
  logic [23:0]              r_side_count;
  logic                     w_side_active;
  logic                     w_side_full;
  logic                     w_release;
  logic                     w_emit;
  logic                     w_last;
  host_cmd_pkg::resp_word_u w_word;

  assign w_side_active = |o_rpath_activate;
  assign w_side_full   = r_side_count >= i_rpath_size;

  // Partly filled side goes back to the reader once the response is over
  assign w_release = r_finish && (r_side_count != '0);

  assign w_emit = r_busy && w_side_active && !w_side_full && !w_release;

  // Header, read size and address come before the data words
  assign w_last = r_word_idx == (i_read_size + 32'd2);

  // Word for the current index
  always_comb begin
    w_word.data = '0;
    case (r_word_idx)
      32'd0: begin
        w_word.hdr.id       = host_cmd_pkg::STATUS_ID_RESP;
        w_word.hdr.flags    = i_flag;
        w_word.hdr.opcode_n = ~i_opcode;
      end
      32'd1: begin
        w_word.data = i_read_size;
      end
      32'd2: begin
        w_word.data = i_address;
      end
      default: begin
        // Generated read data is the running data index
        w_word.data = r_word_idx - 32'd3;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_rpath_activate <= '0;
      o_rpath_strobe   <= 1'b0;
      o_status_rdy_stb <= 1'b0;
      o_send_done      <= 1'b0;
      r_busy           <= 1'b0;
      r_finish         <= 1'b0;
      r_word_idx       <= '0;
      r_side_count     <= '0;
    end else begin
      o_rpath_strobe   <= 1'b0;
      o_status_rdy_stb <= 1'b0;
      o_send_done      <= r_finish;
      r_finish         <= 1'b0;

      if (i_send_go) begin
        r_busy     <= 1'b1;
        r_word_idx <= '0;
      end

      // Side selection, side 0 first
      if (!w_side_active) begin
        if (|i_rpath_ready) begin
          r_side_count     <= '0;
          o_rpath_activate <= i_rpath_ready[0] ? 2'b01 : 2'b10;
        end
      end else if (w_side_full || w_release) begin
        // Full side stalls the response until another side is ready
        o_rpath_activate <= '0;
      end

      if (w_emit) begin
        o_rpath_strobe <= 1'b1;
        r_side_count   <= r_side_count + 24'd1;
        r_word_idx     <= r_word_idx + 32'd1;
        if (r_word_idx == 32'd2) begin
          o_status_rdy_stb <= 1'b1;
        end
        if (w_last) begin
          r_busy   <= 1'b0;
          r_finish <= 1'b1;
        end
      end
    end
  end

  // Outgoing word and last header
  always_ff @(posedge clk) begin
    if (w_emit) begin
      o_rpath_data <= w_word;
      if (r_word_idx == 32'd0) begin
        o_status <= w_word;
      end
    end
  end

endmodule

/* design/write_drain.sv */
`timescale 1ns/1ps

module write_drain (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_drain_en,
  input  logic        i_wpath_ready,
  input  logic [23:0] i_wpath_packet_size,
  output logic        o_wpath_activate,
  output logic        o_wpath_strobe,
  output logic [31:0] o_words_taken
);

  logic [23:0] r_pkt_count;
  logic [23:0] r_pkt_size;
  logic        w_claim;
  logic        w_pkt_full;
  logic        w_take;

  // Claim a buffer as soon as the producer has one
  assign w_claim = !o_wpath_activate && i_wpath_ready;

  assign w_pkt_full = r_pkt_count >= r_pkt_size;

  // One word per cycle while the packet still has words and the decoder wants them
  assign w_take = o_wpath_activate && !w_pkt_full && i_drain_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_wpath_activate <= 1'b0;
      o_wpath_strobe   <= 1'b0;
      r_pkt_count      <= '0;
      o_words_taken    <= '0;
    end else begin
      o_wpath_strobe <= 1'b0;

      if (w_claim) begin
        o_wpath_activate <= 1'b1;
        r_pkt_count      <= '0;
      end else if (o_wpath_activate && w_pkt_full) begin
        // Whole packet taken, hand the buffer back
        o_wpath_activate <= 1'b0;
      end

      if (w_take) begin
        o_wpath_strobe <= 1'b1;
        r_pkt_count    <= r_pkt_count + 24'd1;
      end

      // Total restarts for each data-taking command
      if (!i_drain_en) begin
        o_words_taken <= '0;
      end else if (w_take) begin
        o_words_taken <= o_words_taken + 32'd1;
      end
    end
  end

  // Packet length held for the whole activation
  always_ff @(posedge clk) begin
    if (w_claim) begin
      r_pkt_size <= i_wpath_packet_size;
    end
  end

endmodule

/* project.f */
design/host_cmd_pkg.sv
design/cmd_decode.sv
design/write_drain.sv
design/response_sender.sv
design/host_master.sv
tb/host_master_assert.sv
tb/host_master_tb.sv

/* tb/host_master_assert.sv */
`timescale 1ns/1ps

module host_master_assert #(
  parameter bit CHECK_STATUS = 1'b1
) (
  input logic        clk,
  input logic        rst,
  input logic        i_active,
  input logic        i_strobe,
  input logic [23:0] i_limit,
  input logic        i_status_stb,
  input logic        i_done
);

  logic [23:0] strobe_count;
  int          failures = 0;

  // Strobes seen in the current activation
  always_ff @(posedge clk) begin
    if (rst || !i_active) begin
      strobe_count <= '0;
    end else if (i_strobe) begin
      strobe_count <= strobe_count + 24'd1;
    end
  end

  a_strobe_active: assert property (@(posedge clk) disable iff (rst)
    i_strobe |-> i_active)
    else begin
      $error("FIFO strobe without activate");
      failures++;
    end

  a_strobe_limit: assert property (@(posedge clk) disable iff (rst)
    i_strobe |-> (strobe_count < i_limit))
    else begin
      $error("More FIFO strobes than the activation allows");
      failures++;
    end

  // Only the response side has a status strobe
  if (CHECK_STATUS) begin : g_status
    logic status_open;

    // Status sent but response not yet finished
    always_ff @(posedge clk) begin
      if (rst || i_done) begin
        status_open <= 1'b0;
      end else if (i_status_stb) begin
        status_open <= 1'b1;
      end
    end

    a_status_once: assert property (@(posedge clk) disable iff (rst)
      i_status_stb |-> !status_open)
      else begin
        $error("Second status strobe before the response finished");
        failures++;
      end
  end

endmodule

bind response_sender host_master_assert #(.CHECK_STATUS(1'b1)) u_rpath_assert (
  .clk          (clk),
  .rst          (rst),
  .i_active     (|o_rpath_activate),
  .i_strobe     (o_rpath_strobe),
  .i_limit      (i_rpath_size),
  .i_status_stb (o_status_rdy_stb),
  .i_done       (o_send_done)
);

bind write_drain host_master_assert #(.CHECK_STATUS(1'b0)) u_wpath_assert (
  .clk          (clk),
  .rst          (rst),
  .i_active     (o_wpath_activate),
  .i_strobe     (o_wpath_strobe),
  .i_limit      (r_pkt_size),
  .i_status_stb (1'b0),
  .i_done       (1'b0)
);

/* tb/host_master_tb.sv */
`timescale 1ns/1ps

module host_master_tb;

  localparam int WAIT_LIMIT = 2000;

  logic                     clk;
  logic                     rst;
  logic [7:0]               i_command;
  logic [7:0]               i_flag;
  logic [31:0]              i_rw_count;
  logic [31:0]              i_address;
  logic                     i_command_rdy_stb;
  logic                     o_master_ready;
  host_cmd_pkg::resp_word_u o_status;
  logic                     o_status_rdy_stb;
  logic                     i_wpath_ready;
  logic [23:0]              i_wpath_packet_size;
  logic                     o_wpath_activate;
  logic                     o_wpath_strobe;
  logic [1:0]               i_rpath_ready;
  logic [23:0]              i_rpath_size;
  logic [1:0]               o_rpath_activate;
  host_cmd_pkg::resp_word_u o_rpath_data;
  logic                     o_rpath_strobe;

  host_cmd_pkg::resp_word_u rx_q[$];
  int          in_strobes = 0;
  int          status_pulses = 0;
  int          mismatch_count = 0;
  int          failure_count = 0;
  logic [31:0] lfsr_state;
  logic [31:0] model_state;
  int          side_delay[2];
  logic [1:0]  side_was_active;

  host_master uut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [31:0] model_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], model_state[0]};
      model_state = lfsr_step(model_state);
    end
    return v;
  endfunction

  // FIFO-side monitor on the values registered before the edge
  always @(posedge clk) begin
    if (o_rpath_strobe === 1'b1) rx_q.push_back(o_rpath_data);
    if (o_wpath_strobe === 1'b1) in_strobes++;
    if (o_status_rdy_stb === 1'b1) status_pulses++;
  end

  // Outgoing ping-pong FIFO model
  // A released side comes back ready after a short random delay
  initial begin
    i_rpath_ready   = 2'b11;
    side_was_active = 2'b00;
    model_state     = 32'h6345;
    side_delay[0]   = 0;
    side_delay[1]   = 0;
    forever begin
      @(posedge clk);
      #2;
      for (int s = 0; s < 2; s++) begin
        if (o_rpath_activate[s] && i_rpath_ready[s]) begin
          i_rpath_ready[s] = 1'b0;
        end else if (side_was_active[s] && !o_rpath_activate[s]) begin
          side_delay[s] = 1 + int'(model_bits(2));
        end else if (side_delay[s] != 0) begin
          side_delay[s] = side_delay[s] - 1;
          if (side_delay[s] == 0) i_rpath_ready[s] = 1'b1;
        end
        side_was_active[s] = o_rpath_activate[s];
      end
    end
  end

  task automatic finish_run;
    failure_count += uut.u_sender.u_rpath_assert.failures;
    failure_count += uut.u_drain.u_wpath_assert.failures;
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    failure_count++;
    $display("ERROR at %0t: timed out waiting for %s", $time, what);
    finish_run();
  endtask

  task automatic check_word(input string name, input host_cmd_pkg::resp_word_u got,
                            input host_cmd_pkg::resp_word_u exp);
    if (got.data !== exp.data) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got.data, exp.data);
    end
  endtask

  task automatic check_header(input string name, input host_cmd_pkg::resp_word_u got,
                              input logic [7:0] flags, input logic [7:0] opcode);
    if (got.hdr.id !== host_cmd_pkg::STATUS_ID_RESP) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s.id got %h expected %h", $time, name, got.hdr.id,
               host_cmd_pkg::STATUS_ID_RESP);
    end
    if (got.hdr.flags !== flags) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s.flags got %h expected %h", $time, name,
               got.hdr.flags, flags);
    end
    if (got.hdr.opcode_n !== ~opcode) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s.opcode_n got %h expected %h", $time, name,
               got.hdr.opcode_n, ~opcode);
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic wait_words(input int target);
    int n;
    n = 0;
    while (rx_q.size() < target) begin
      if (n == WAIT_LIMIT) report_timeout("response words");
      @(posedge clk);
      #2;
      n++;
    end
  endtask

  task automatic wait_idle;
    int n;
    n = 0;
    while (uut.cmd_state !== host_cmd_pkg::ST_IDLE) begin
      if (n == WAIT_LIMIT) report_timeout("command FSM to return to IDLE");
      @(posedge clk);
      #2;
      n++;
    end
  endtask

  task automatic wait_wpath_activate(input logic level);
    int n;
    n = 0;
    while (o_wpath_activate !== level) begin
      if (n == WAIT_LIMIT) report_timeout("incoming FIFO activate");
      @(posedge clk);
      #2;
      n++;
    end
  endtask

  // Incoming producer handing over exactly total words in random packets
  task automatic feed_incoming(input int total);
    int left;
    int size;
    int base;
    left = total;
    while (left > 0) begin
      repeat (rand_bits(2)) begin
        @(posedge clk);
        #2;
      end
      size = 1 + int'(rand_bits(3));
      if (size > left) size = left;
      i_wpath_packet_size = 24'(size);
      i_wpath_ready = 1'b1;
      wait_wpath_activate(1'b1);
      i_wpath_ready = 1'b0;
      base = in_strobes;
      wait_wpath_activate(1'b0);
      check_count("packet strobes", 32'(in_strobes - base), 32'(size));
      left -= size;
    end
  endtask

  // One command from strobe to IDLE and a check of the whole response
  task automatic exchange(input logic [7:0] cmd, input logic [31:0] count,
                          input int take, input int rsize);
    logic [7:0]               flag;
    logic [31:0]              addr;
    int                       base_w;
    int                       base_in;
    int                       base_st;
    host_cmd_pkg::resp_word_u exp;
    flag    = 8'(rand_bits(8));
    addr    = rand_bits(32);
    base_w  = rx_q.size();
    base_in = in_strobes;
    base_st = status_pulses;
    i_command         = cmd;
    i_flag            = flag;
    i_rw_count        = count;
    i_address         = addr;
    i_command_rdy_stb = 1'b1;
    @(posedge clk);
    #2;
    i_command_rdy_stb = 1'b0;
    // Ready stays up only while the command wants incoming data
    check_count("o_master_ready", {31'd0, o_master_ready}, 32'(take > 0));
    if (take > 0) begin
      fork
        begin
          feed_incoming(take);
          check_count("words before data taken", 32'(rx_q.size() - base_w), 32'd0);
        end
        wait_words(base_w + 3 + rsize);
      join
    end else begin
      wait_words(base_w + 3 + rsize);
    end
    wait_idle();
    check_count("incoming strobes", 32'(in_strobes - base_in), 32'(take));
    check_count("response words", 32'(rx_q.size() - base_w), 32'(3 + rsize));
    check_count("o_status_rdy_stb pulses", 32'(status_pulses - base_st), 32'd1);
    check_count("o_master_ready", {31'd0, o_master_ready}, 32'd1);
    check_header("header", rx_q[base_w], flag, cmd);
    check_header("o_status", o_status, flag, cmd);
    exp.data = 32'(rsize);
    check_word("read size", rx_q[base_w + 1], exp);
    exp.data = addr;
    check_word("address", rx_q[base_w + 2], exp);
    for (int k = 0; k < rsize; k++) begin
      exp.data = 32'(k);
      check_word("read data", rx_q[base_w + 3 + k], exp);
    end
  endtask

  task automatic do_ping;
    exchange(host_cmd_pkg::CMD_PING, 32'd0, 0, 0);
  endtask

  task automatic do_write;
    int n;
    n = 1 + int'(rand_bits(5));
    exchange(host_cmd_pkg::CMD_WRITE, 32'(n), n, 0);
  endtask

  task automatic do_read(input int n);
    exchange(host_cmd_pkg::CMD_READ, 32'(n), 0, n);
  endtask

  task automatic do_config(input logic take_data);
    int n;
    n = take_data ? 1 + int'(rand_bits(4)) : 0;
    exchange(host_cmd_pkg::CMD_CONFIG, 32'(n), n, int'(host_cmd_pkg::CONFIG_LENGTH));
  endtask

  task automatic check_after_reset;
    repeat (2) begin
      @(posedge clk);
      #2;
    end
    check_count("o_master_ready", {31'd0, o_master_ready}, 32'd1);
    check_count("strobes after reset", 32'(rx_q.size() + in_strobes + status_pulses), 32'd0);
  endtask

  initial begin
    rst                 = 1'b1;
    i_command           = '0;
    i_flag              = '0;
    i_rw_count          = '0;
    i_address           = '0;
    i_command_rdy_stb   = 1'b0;
    i_wpath_ready       = 1'b0;
    i_wpath_packet_size = '0;
    i_rpath_size        = 24'd16;
    lfsr_state          = 32'h6345;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    check_after_reset();
    // Each command twice in a row
    repeat (2) begin
      do_ping();
      do_write();
      do_read(1 + int'(rand_bits(3)));
      do_config(1'b0);
      do_config(1'b1);
    end
    // Small outgoing buffers force side switching mid-response
    i_rpath_size = 24'd4;
    do_read(13);
    do_read(9);
    do_config(1'b1);
    finish_run();
  end

endmodule
